//--- all.f
source/icache_pkg.sv
source/icache_array.sv
source/icache_refill.sv
source/icache_fetch_select.sv
source/l1_instruction_cache.sv
tests/tb_l1_instruction_cache.sv

//--- Makefile
TOP = tb_l1_instruction_cache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tests/tb_l1_instruction_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_l1_instruction_cache;

	localparam int NUM_LINES = 16;
	localparam int INDEX_BITS = $clog2(NUM_LINES);
	localparam int LINE_NUM_BITS = 32 - icache_pkg::OFFSET_BITS;
	localparam int NUM_FETCHES = 1500;
	localparam int TIMEOUT_CYCLES = NUM_FETCHES * 80;
	localparam int NUM_FAULT_PAGES = 3;
	localparam logic [31:0] WINDOW_BASE = 32'h0001_0000;
	localparam int WINDOW_BYTES = 2048;

	logic iCLOCK = 1'b0;
	logic inRESET = 1'b0;
	logic flash = 1'b0;
	logic fetch_req = 1'b0;
	logic [31:0] fetch_addr = '0;
	logic next_lock = 1'b0;
	logic mem_lock = 1'b0;
	logic mem_valid = 1'b0;
	logic mem_pagefault = 1'b0;
	logic [63:0] mem_data = '0;
	wire fetch_lock;
	wire inst0_valid;
	wire [31:0] inst0;
	wire inst1_valid;
	wire [31:0] inst1;
	wire pagefault;
	wire mem_req;
	wire [31:0] mem_addr;
	wire [6:0] hit_count;

	// Reference model
	logic model_valid [NUM_LINES];
	logic [LINE_NUM_BITS-1:0] model_line [NUM_LINES];
	logic [31:0] fault_pages [NUM_FAULT_PAGES];
	logic [31:0] cur_line;
	int model_hits;
	int n_hits;
	int n_faults;
	int n_flashes;
	int n_held;

	// Memory side bookkeeping
	int cycle_count = 0;
	int burst_reqs = 0;
	int req_seen = 0;
	int mem_tick = 0;
	int last_ready = 0;
	int ready_q [$];
	logic [31:0] addr_q [$];

	l1_instruction_cache #(
		.NUM_LINES(NUM_LINES)
	) dut_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flash(flash),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_lock(fetch_lock),
		.inst0_valid(inst0_valid),
		.inst0(inst0),
		.inst1_valid(inst1_valid),
		.inst1(inst1),
		.pagefault(pagefault),
		.next_lock(next_lock),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_addr(mem_addr),
		.mem_valid(mem_valid),
		.mem_pagefault(mem_pagefault),
		.mem_data(mem_data),
		.hit_count(hit_count)
	);

	always #5 iCLOCK = ~iCLOCK;

	task automatic mismatch(input string signal_name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, signal_name,
			expected, actual);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic stop_with(input string what);
		$display("%s (at %0t ns)", what, $time);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// Memory contents as a fixed mix of the beat address
	function automatic logic [63:0] beat_word(input logic [31:0] beat_addr);
		logic [31:0] hi;
		logic [31:0] lo;
		hi = (beat_addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
		lo = (beat_addr ^ 32'hc2b2_ae35) * 32'h27d4_eb2f;
		return {hi, lo};
	endfunction

	function automatic logic [31:0] line_base(input logic [31:0] addr);
		return {addr[31:icache_pkg::OFFSET_BITS], {icache_pkg::OFFSET_BITS{1'b0}}};
	endfunction

	// Fault pages are one beat wide, so a fault can land on any beat of a line
	function automatic logic beat_faults(input logic [31:0] beat_addr);
		logic f;
		f = 1'b0;
		for (int i = 0; i < NUM_FAULT_PAGES; i++) begin
			if (fault_pages[i] == beat_addr) begin
				f = 1'b1;
			end
		end
		return f;
	endfunction

	function automatic logic line_faults(input logic [31:0] addr);
		logic f;
		f = 1'b0;
		for (int b = 0; b < icache_pkg::BEATS_PER_LINE; b++) begin
			if (beat_faults(line_base(addr) + 32'(b * 8))) begin
				f = 1'b1;
			end
		end
		return f;
	endfunction

	always @(posedge iCLOCK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with("Timeout, the run did not finish within the cycle limit");
		end
	end

	// Memory returns beats in order 1 to 4 cycles after each accepted request
	always begin : memory_responder
		int ready;
		logic [31:0] beat_addr;
		@(negedge iCLOCK);
		if (!mem_req) begin
			req_seen = 0;
		end else if (!mem_lock) begin
			assert (mem_addr == cur_line + 32'(req_seen * 8))
				else mismatch("mem_addr", 64'(cur_line + 32'(req_seen * 8)), 64'(mem_addr));
			ready = mem_tick + 1 + int'($urandom % 4);
			if (ready <= last_ready) begin
				ready = last_ready + 1;
			end
			last_ready = ready;
			ready_q.push_back(ready);
			addr_q.push_back(mem_addr);
			req_seen++;
			burst_reqs++;
		end
		@(posedge iCLOCK);
		mem_tick++;
		mem_lock <= ($urandom % 4 == 0);
		if (ready_q.size() > 0 && ready_q[0] <= mem_tick) begin
			ready = ready_q.pop_front();
			beat_addr = addr_q.pop_front();
			mem_valid <= 1'b1;
			mem_data <= beat_word(beat_addr);
			mem_pagefault <= beat_faults(beat_addr);
		end else begin
			mem_valid <= 1'b0;
			mem_pagefault <= 1'b0;
		end
	end

	task automatic check_reset_outputs();
		assert (!inst0_valid) else mismatch("inst0_valid", 64'(0), 64'(inst0_valid));
		assert (!inst1_valid) else mismatch("inst1_valid", 64'(0), 64'(inst1_valid));
		assert (!pagefault) else mismatch("pagefault", 64'(0), 64'(pagefault));
		assert (!mem_req) else mismatch("mem_req", 64'(0), 64'(mem_req));
		assert (!fetch_lock) else mismatch("fetch_lock", 64'(0), 64'(fetch_lock));
		assert (!dut_i.line_wr) else mismatch("line_wr", 64'(0), 64'(dut_i.line_wr));
		assert (hit_count == 7'd0) else mismatch("hit_count", 64'(0), 64'(hit_count));
	endtask

	task automatic flash_cache();
		@(posedge iCLOCK);
		flash <= 1'b1;
		@(posedge iCLOCK);
		flash <= 1'b0;
		for (int i = 0; i < NUM_LINES; i++) begin
			model_valid[i] = 1'b0;
		end
		n_flashes++;
	endtask

	task automatic run_fetch(input logic [31:0] addr);
		int idx;
		int reqs_before;
		logic exp_hit;
		logic exp_fault;
		logic [63:0] beat;
		logic [31:0] exp0;
		logic done;
		idx = int'(addr[icache_pkg::OFFSET_BITS +: INDEX_BITS]);
		exp_hit = model_valid[idx] && (model_line[idx] == addr[31:icache_pkg::OFFSET_BITS]);
		exp_fault = !exp_hit && line_faults(addr);
		beat = beat_word({addr[31:3], 3'b000});
		exp0 = addr[2] ? beat[63:32] : beat[31:0];
		reqs_before = burst_reqs;
		cur_line = line_base(addr);

		@(posedge iCLOCK);
		fetch_req <= 1'b1;
		fetch_addr <= addr;
		next_lock <= 1'b0;
		@(negedge iCLOCK);
		assert (!fetch_lock) else stop_with("Cache stayed locked with no fetch in flight");

		// Result must come on the first cycle without next_lock for a hit
		done = 1'b0;
		while (!done) begin
			@(posedge iCLOCK);
			fetch_req <= 1'b0;
			next_lock <= ($urandom % 4 == 0);
			@(negedge iCLOCK);
			if (!next_lock && inst0_valid) begin
				done = 1'b1;
			end else begin
				assert (!inst0_valid && !inst1_valid && !pagefault)
					else stop_with("Instruction output valid while next_lock was high");
				assert (next_lock || !exp_hit)
					else stop_with("Hit not returned on the first cycle without next_lock");
				if (exp_hit) begin
					n_held++;
				end
			end
		end

		assert (pagefault == exp_fault) else mismatch("pagefault", 64'(exp_fault), 64'(pagefault));
		assert (inst1_valid == !addr[2])
			else mismatch("inst1_valid", 64'(!addr[2]), 64'(inst1_valid));
		if (!exp_fault) begin
			assert (inst0 == exp0) else mismatch("inst0", 64'(exp0), 64'(inst0));
			if (!addr[2]) begin
				assert (inst1 == beat[63:32]) else mismatch("inst1", 64'(beat[63:32]), 64'(inst1));
			end
		end
		assert (hit_count == 7'(model_hits))
			else mismatch("hit_count", 64'(model_hits), 64'(hit_count));

		// Burst length seen by memory
		if (exp_hit) begin
			assert (burst_reqs == reqs_before)
				else mismatch("burst requests", 64'(0), 64'(burst_reqs - reqs_before));
			if (model_hits < 127) begin
				model_hits++;
			end
			n_hits++;
		end else if (!exp_fault) begin
			assert (burst_reqs - reqs_before == icache_pkg::BEATS_PER_LINE)
				else mismatch("burst requests", 64'(8), 64'(burst_reqs - reqs_before));
			model_valid[idx] = 1'b1;
			model_line[idx] = addr[31:icache_pkg::OFFSET_BITS];
		end else begin
			assert (burst_reqs - reqs_before >= 1)
				else mismatch("burst requests", 64'(1), 64'(burst_reqs - reqs_before));
			n_faults++;
		end
	endtask

	initial begin : main
		int unsigned seed_ret;
		logic [31:0] addr;
		seed_ret = $urandom(32'hef7a318b);
		for (int i = 0; i < NUM_LINES; i++) begin
			model_valid[i] = 1'b0;
			model_line[i] = '0;
		end
		for (int i = 0; i < NUM_FAULT_PAGES; i++) begin
			fault_pages[i] = WINDOW_BASE + (($urandom % (WINDOW_BYTES / 8)) * 8);
		end
		model_hits = 0;
		n_hits = 0;
		n_faults = 0;
		n_flashes = 0;
		n_held = 0;
		cur_line = '0;

		// 16 cycles of reset
		repeat (4) @(negedge iCLOCK);
		check_reset_outputs();
		repeat (12) @(posedge iCLOCK);
		inRESET <= 1'b1;

		for (int n = 0; n < NUM_FETCHES; n++) begin
			addr = WINDOW_BASE + (($urandom % WINDOW_BYTES) & 32'hffff_fffc);
			run_fetch(addr);
			if ($urandom % 64 == 0) begin
				flash_cache();
			end
		end

		@(negedge iCLOCK);
		assert (hit_count == 7'(model_hits))
			else mismatch("hit_count", 64'(model_hits), 64'(hit_count));
		assert (n_hits > 0 && n_faults > 0 && n_flashes > 0 && n_held > 0)
			else stop_with("Stimulus never reached hits, faults, flashes and held results");
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/l1_instruction_cache.sv
`timescale 1ns/1ns
`default_nettype none

module l1_instruction_cache #(
	parameter int NUM_LINES = 16
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire flash,
	// Fetch request
	input wire fetch_req,
	input wire [31:0] fetch_addr,
	output wire fetch_lock,
	// Instruction result
	output wire inst0_valid,
	output wire [31:0] inst0,
	output wire inst1_valid,
	output wire [31:0] inst1,
	output wire pagefault,
	input wire next_lock,
	// Memory burst port
	output wire mem_req,
	input wire mem_lock,
	output wire [31:0] mem_addr,
	input wire mem_valid,
	input wire mem_pagefault,
	input wire [63:0] mem_data,
	output wire [6:0] hit_count
);

	logic lookup_req;
	logic addr_bit2;
	logic hit_valid;
	logic hit;
	icache_pkg::beat_u hit_beat;
	logic refill_idle;
	logic refill_out;
	logic refill_slot1_ok;
	icache_pkg::beat_u refill_beat;
	logic refill_fault;
	logic line_wr;
	logic [31:0] line_addr;
	logic [icache_pkg::LINE_BYTES*8-1:0] line_data;

	// Request accepted
	assign lookup_req = fetch_req && !fetch_lock;

	// Word select of the request in flight
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			addr_bit2 <= 1'b0;
		end else if (lookup_req) begin
			addr_bit2 <= fetch_addr[2];
		end
	end

	icache_array #(
		.NUM_LINES(NUM_LINES)
	) array_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flash(flash),
		.lookup_req(lookup_req),
		.lookup_addr(fetch_addr),
		.line_wr(line_wr),
		.line_addr(line_addr),
		.line_data(line_data),
		.hit_valid(hit_valid),
		.hit(hit),
		.hit_beat(hit_beat)
	);

	icache_refill refill_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.lookup_req(lookup_req),
		.lookup_addr(fetch_addr),
		.hit_valid(hit_valid),
		.hit(hit),
		.next_lock(next_lock),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_addr(mem_addr),
		.mem_valid(mem_valid),
		.mem_pagefault(mem_pagefault),
		.mem_data(mem_data),
		.refill_idle(refill_idle),
		.refill_out(refill_out),
		.refill_slot1_ok(refill_slot1_ok),
		.refill_beat(refill_beat),
		.refill_fault(refill_fault),
		.line_wr(line_wr),
		.line_addr(line_addr),
		.line_data(line_data)
	);

	icache_fetch_select select_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.hit_valid(hit_valid),
		.hit(hit),
		.hit_beat(hit_beat),
		.addr_bit2(addr_bit2),
		.refill_out(refill_out),
		.refill_slot1_ok(refill_slot1_ok),
		.refill_beat(refill_beat),
		.refill_fault(refill_fault),
		.refill_idle(refill_idle),
		.next_lock(next_lock),
		.inst0_valid(inst0_valid),
		.inst0(inst0),
		.inst1_valid(inst1_valid),
		.inst1(inst1),
		.pagefault(pagefault),
		.fetch_lock(fetch_lock),
		.hit_count(hit_count)
	);

endmodule

`default_nettype wire

//--- source/icache_fetch_select.sv
`timescale 1ns/1ns
`default_nettype none

module icache_fetch_select (
	input wire iCLOCK,
	input wire inRESET,
	// Hit path from the array
	input wire hit_valid,
	input wire hit,
	input wire icache_pkg::beat_u hit_beat,
	input wire addr_bit2,
	// Refill path
	input wire refill_out,
	input wire refill_slot1_ok,
	input wire icache_pkg::beat_u refill_beat,
	input wire refill_fault,
	input wire refill_idle,
	input wire next_lock,
	// To the fetch unit
	output logic inst0_valid,
	output logic [31:0] inst0,
	output logic inst1_valid,
	output logic [31:0] inst1,
	output logic pagefault,
	output logic fetch_lock,
	output logic [6:0] hit_count
);

	logic hit_hold;
	logic hit_avail;
	logic slot0_ok;
	logic slot1_ok;
	logic hit_taken;

	// A hit seen under next_lock stays pending until it is taken
	assign hit_avail = (hit_valid && hit) || hit_hold;
	assign hit_taken = hit_avail && !refill_out && !next_lock;

	always_comb begin
		if (refill_out) begin
			slot0_ok = 1'b1;
			slot1_ok = refill_slot1_ok;
			inst0 = refill_beat.slots.lo;
			inst1 = refill_beat.slots.hi;
		end else begin
			slot0_ok = hit_avail;
			slot1_ok = hit_avail && !addr_bit2;
			// Odd word address starts in the upper half
			inst0 = addr_bit2 ? hit_beat.slots.hi : hit_beat.slots.lo;
			inst1 = hit_beat.slots.hi;
		end
	end

	assign inst0_valid = slot0_ok && !next_lock;
	assign inst1_valid = slot1_ok && !next_lock;
	assign pagefault = refill_out && refill_fault && !next_lock;

	assign fetch_lock = !refill_idle || (hit_valid && !hit) || next_lock;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hit_hold <= 1'b0;
			hit_count <= '0;
		end else begin
			hit_hold <= hit_avail && !refill_out && next_lock;
			// Saturating count of delivered hits
			if (hit_taken && (hit_count != 7'h7f)) begin
				hit_count <= hit_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill (
	input wire iCLOCK,
	input wire inRESET,
	// Request capture and lookup result
	input wire lookup_req,
	input wire [31:0] lookup_addr,
	input wire hit_valid,
	input wire hit,
	input wire next_lock,
	// Memory burst port
	output logic mem_req,
	input wire mem_lock,
	output logic [31:0] mem_addr,
	input wire mem_valid,
	input wire mem_pagefault,
	input wire [63:0] mem_data,
	// Result to the selector
	output logic refill_idle,
	output logic refill_out,
	output logic refill_slot1_ok,
	output icache_pkg::beat_u refill_beat,
	output logic refill_fault,
	// Line write to the array
	output logic line_wr,
	output logic [31:0] line_addr,
	output logic [icache_pkg::LINE_BYTES*8-1:0] line_data
);

	localparam int LINE_BITS = icache_pkg::LINE_BYTES * 8;
	localparam int BEAT_BITS = $clog2(icache_pkg::BEATS_PER_LINE);
	localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(icache_pkg::BEATS_PER_LINE - 1);

	icache_pkg::refill_state_e state;
	logic [BEAT_BITS-1:0] req_cnt;
	logic [BEAT_BITS-1:0] get_cnt;
	logic [BEAT_BITS:0] out_cnt;
	logic [31:0] req_addr;
	logic [LINE_BITS-1:0] line_buf;
	icache_pkg::beat_u in_beat;
	icache_pkg::beat_u crit_beat;
	logic [BEAT_BITS-1:0] crit_idx;
	logic fault;
	logic req_fire;
	logic collecting;
	logic crit_take;
	logic drained;

	assign in_beat.raw = mem_data;
	assign crit_idx = req_addr[icache_pkg::OFFSET_BITS-1 -: BEAT_BITS];
	assign req_fire = mem_req && !mem_lock;
	assign collecting = (state == icache_pkg::MEMREQ) || (state == icache_pkg::MEMGET);
	// A fault before the critical beat still leaves something in slot 0
	assign crit_take = mem_pagefault ? (get_cnt <= crit_idx) : (get_cnt == crit_idx);
	// Beats still in flight after an aborted burst must land before we finish
	assign drained = (out_cnt == '0);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= icache_pkg::IDLE;
			req_cnt <= '0;
			get_cnt <= '0;
			out_cnt <= '0;
			fault <= 1'b0;
		end else begin
			case ({req_fire, mem_valid})
				2'b10: out_cnt <= out_cnt + 1'b1;
				2'b01: out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt;
			endcase
			case (state)
				icache_pkg::IDLE: begin
					req_cnt <= '0;
					get_cnt <= '0;
					fault <= 1'b0;
					if (hit_valid && !hit) begin
						state <= icache_pkg::MEMREQ;
					end
				end
				icache_pkg::MEMREQ: begin
					// Only unlocked cycles advance the address
					if (req_fire) begin
						if (req_cnt == LAST_BEAT) begin
							state <= icache_pkg::MEMGET;
						end else begin
							req_cnt <= req_cnt + 1'b1;
						end
					end
				end
				icache_pkg::MEMGET: begin
					state <= icache_pkg::MEMGET;
				end
				icache_pkg::OUTINST: begin
					if (drained && !next_lock) begin
						state <= icache_pkg::IDLE;
					end
				end
				default: state <= icache_pkg::IDLE;
			endcase
			// Beat returns may overlap the request phase
			if (collecting && mem_valid) begin
				get_cnt <= get_cnt + 1'b1;
				if (mem_pagefault) begin
					fault <= 1'b1;
					state <= icache_pkg::OUTINST;
				end else if (get_cnt == LAST_BEAT) begin
					state <= icache_pkg::OUTINST;
				end
			end
		end
	end

	// Request address, line buffer and critical beat
	always_ff @(posedge iCLOCK) begin
		if (lookup_req) begin
			req_addr <= lookup_addr;
		end
		if (collecting && mem_valid) begin
			line_buf <= {in_beat.raw, line_buf[LINE_BITS-1:64]};
			if (crit_take) begin
				if (req_addr[2]) begin
					crit_beat.slots.lo <= in_beat.slots.hi;
					crit_beat.slots.hi <= '0;
				end else begin
					crit_beat <= in_beat;
				end
			end
		end
	end

	assign mem_req = (state == icache_pkg::MEMREQ);
	assign mem_addr = {req_addr[31:icache_pkg::OFFSET_BITS], req_cnt, 3'b000};

	assign refill_idle = (state == icache_pkg::IDLE);
	assign refill_out = (state == icache_pkg::OUTINST) && drained;
	assign refill_slot1_ok = !req_addr[2];
	assign refill_beat = crit_beat;
	assign refill_fault = fault;

	// Line goes in on the cycle the result is taken and never after a fault
	assign line_wr = refill_out && !next_lock && !fault;
	assign line_addr = {req_addr[31:icache_pkg::OFFSET_BITS], {icache_pkg::OFFSET_BITS{1'b0}}};
	assign line_data = line_buf;

	// The burst ends with the eighth accepted request
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(req_fire && (req_cnt == LAST_BEAT)) |=> !mem_req)
		else $error("icache_refill: mem_req after the last beat request");

	// Every returned beat belongs to a burst this engine issued
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(state == icache_pkg::IDLE) |-> !mem_valid)
		else $error("icache_refill: memory beat while idle");

endmodule

`default_nettype wire

//--- source/icache_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_array #(
	parameter int NUM_LINES = 16
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire flash,
	// Lookup port
	input wire lookup_req,
	input wire [31:0] lookup_addr,
	// Line write from the refill engine
	input wire line_wr,
	input wire [31:0] line_addr,
	input wire [icache_pkg::LINE_BYTES*8-1:0] line_data,
	// Lookup result, one cycle after the request
	output logic hit_valid,
	output logic hit,
	output icache_pkg::beat_u hit_beat
);

	localparam int INDEX_BITS = $clog2(NUM_LINES);
	localparam int TAG_BITS = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS;
	localparam int LINE_BITS = icache_pkg::LINE_BYTES * 8;
	localparam int BEAT_BITS = $clog2(icache_pkg::BEATS_PER_LINE);

	logic [NUM_LINES-1:0] valid;
	logic [TAG_BITS-1:0] tag_mem [NUM_LINES];
	logic [LINE_BITS-1:0] data_mem [NUM_LINES];

	logic [INDEX_BITS-1:0] lk_index;
	logic [TAG_BITS-1:0] lk_tag;
	logic [BEAT_BITS-1:0] lk_beat;
	logic [INDEX_BITS-1:0] wr_index;
	logic [TAG_BITS-1:0] wr_tag;
	logic lk_match;

	// Address split into tag, index, beat, word and byte
	assign lk_index = lookup_addr[icache_pkg::OFFSET_BITS +: INDEX_BITS];
	assign lk_tag = lookup_addr[31 -: TAG_BITS];
	assign lk_beat = lookup_addr[icache_pkg::OFFSET_BITS-1 -: BEAT_BITS];
	assign wr_index = line_addr[icache_pkg::OFFSET_BITS +: INDEX_BITS];
	assign wr_tag = line_addr[31 -: TAG_BITS];

	assign lk_match = valid[lk_index] && (tag_mem[lk_index] == lk_tag);

	// Flash has priority over a fill for the valid bits
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid <= '0;
		end else if (flash) begin
			valid <= '0;
		end else if (line_wr) begin
			valid[wr_index] <= 1'b1;
		end
	end

	// Lookup status
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hit_valid <= 1'b0;
			hit <= 1'b0;
		end else begin
			hit_valid <= lookup_req;
			if (lookup_req) begin
				hit <= lk_match;
			end
		end
	end

	// Tag and line storage
	always_ff @(posedge iCLOCK) begin
		if (line_wr) begin
			tag_mem[wr_index] <= wr_tag;
			data_mem[wr_index] <= line_data;
		end
	end

	// Beat is kept until the next lookup so a held hit stays stable
	always_ff @(posedge iCLOCK) begin
		if (lookup_req) begin
			hit_beat.raw <= data_mem[lk_index][lk_beat * 64 +: 64];
		end
	end

	// Lookups are locked out for the whole refill, including the write cycle
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(lookup_req && line_wr))
		else $error("icache_array: lookup and line write in the same cycle");

endmodule

`default_nettype wire

//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// Line geometry
	localparam int LINE_BYTES = 64;
	localparam int BEATS_PER_LINE = 8;
	localparam int OFFSET_BITS = 6;

	// One 64-bit memory beat
	// Seen whole when it enters the line buffer,
	// or as two instruction words when it feeds the slots
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} beat_slots_t;

	typedef union packed {
		logic [63:0] raw;
		beat_slots_t slots;
	} beat_u;

	// Miss engine states
	typedef enum logic [1:0] {
		IDLE = 2'h0,
		MEMREQ = 2'h1,
		MEMGET = 2'h2,
		OUTINST = 2'h3
	} refill_state_e;

endpackage

`default_nettype wire
